// File: source/spi_lcd_pkg.sv
package spi_lcd_pkg;

  // One queued byte and its data/command tag.
  typedef struct packed {
    logic       cmd;
    logic [7:0] payload;
  } lcd_entry_t;

  // Register word indices, matched against bus address bits 15 to 2.
  localparam logic [13:0] REG_STATUS = 14'd0;
  localparam logic [13:0] REG_CMD    = 14'd1;
  localparam logic [13:0] REG_DATA   = 14'd2;

  // Status word layout.
  localparam int STAT_IDLE_BIT   = 0;
  localparam int STAT_OVF_BIT    = 1;
  localparam int STAT_CREDIT_LSB = 8;

  // Width of a credit count, enough for FIFO_DEPTH up to 255.
  localparam int CREDIT_W = 8;

endpackage

// File: source/lcd_bus_regs.sv
`timescale 1ns/1ps

module lcd_bus_regs #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  logic                    i_bus_req,
  input  logic                    i_bus_write,
  input  logic [31:0]             i_bus_addr,
  input  logic [31:0]             i_bus_data,
  input  logic                    i_credit_return,
  input  logic                    i_idle,
  output logic                    o_bus_ack,
  output logic [31:0]             o_bus_data,
  output logic                    o_push_valid,
  output spi_lcd_pkg::lcd_entry_t o_push_entry
);

  localparam int CW = spi_lcd_pkg::CREDIT_W;

  logic [13:0]   word_idx;
  logic          wr_req;
  logic          rd_req;
  logic          hit_status;
  logic          hit_cmd;
  logic          hit_data;
  logic          has_credit;
  logic          push_now;
  logic          drop_now;
  logic          ovf_clear;
  logic [CW-1:0] credits;
  logic          overflow;
  logic [31:0]   status_word;

  assign word_idx   = i_bus_addr[15:2];
  assign wr_req     = i_bus_req && i_bus_write;
  assign rd_req     = i_bus_req && !i_bus_write;
  assign hit_status = (word_idx == spi_lcd_pkg::REG_STATUS);
  assign hit_cmd    = (word_idx == spi_lcd_pkg::REG_CMD);
  assign hit_data   = (word_idx == spi_lcd_pkg::REG_DATA);
  assign has_credit = (credits != '0);

  // A byte write either spends a credit or is dropped.
  assign push_now  = wr_req && (hit_cmd || hit_data) && has_credit;
  assign drop_now  = wr_req && (hit_cmd || hit_data) && !has_credit;
  assign ovf_clear = wr_req && hit_status && i_bus_data[spi_lcd_pkg::STAT_OVF_BIT];

  always_comb begin
    status_word = '0;
    status_word[spi_lcd_pkg::STAT_IDLE_BIT] = i_idle;
    status_word[spi_lcd_pkg::STAT_OVF_BIT]  = overflow;
    status_word[spi_lcd_pkg::STAT_CREDIT_LSB +: CW] = credits;
  end

  // Bus handshake; ack and read data follow the request by one cycle.
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_bus_ack    <= 1'b0;
      o_bus_data   <= '0;
      o_push_valid <= 1'b0;
    end else begin
      o_bus_ack    <= i_bus_req;
      o_bus_data   <= rd_req ? status_word : 32'd0;
      o_push_valid <= push_now;
    end
  end

  // Entry register.
  always_ff @(posedge clk) begin
    if (push_now) begin
      o_push_entry.cmd     <= hit_cmd;
      o_push_entry.payload <= i_bus_data[7:0];
    end
  end

  // One credit per free FIFO slot.
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      credits <= CW'(FIFO_DEPTH);
    end else begin
      case ({push_now, i_credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Sticky until software writes bit 1 of the status word.
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      overflow <= 1'b0;
    end else if (drop_now) begin
      overflow <= 1'b1;
    end else if (ovf_clear) begin
      overflow <= 1'b0;
    end
  end

endmodule

// File: source/entry_fifo.sv
`timescale 1ns/1ps

module entry_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  logic                    i_push_valid,
  input  spi_lcd_pkg::lcd_entry_t i_push_entry,
  input  logic                    i_pop,
  output spi_lcd_pkg::lcd_entry_t o_head,
  output logic                    o_not_empty,
  output logic                    o_credit_return
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  spi_lcd_pkg::lcd_entry_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  assign o_not_empty = (count != '0);
  assign do_pop      = i_pop && o_not_empty;
  assign o_head      = mem[rd_ptr];

  // Room is guaranteed by the credits held in the register block.
  assign o_credit_return = do_pop;

  always_ff @(posedge clk) begin
    if (i_push_valid) begin
      mem[wr_ptr] <= i_push_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({i_push_valid, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: source/spi_byte_shifter.sv
`timescale 1ns/1ps

module spi_byte_shifter #(
  parameter int SCK_HALF = 2
) (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  spi_lcd_pkg::lcd_entry_t i_entry,
  input  logic                    i_entry_valid,
  input  logic                    i_spi_ack,
  output logic                    o_pop,
  output logic                    o_spi_req,
  output logic                    o_spi_done,
  output logic                    o_sck,
  output logic                    o_cs,
  output logic                    o_rs_dc,
  output logic                    o_data,
  output logic                    o_idle
);

  localparam int DIV_W = (SCK_HALF > 1) ? $clog2(SCK_HALF) : 1;

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_SHIFT,
    S_FINISH
  } state_t;

  state_t           state;
  logic [DIV_W-1:0] div_cnt;
  logic [2:0]       bit_cnt;
  logic [7:0]       shreg;
  logic             done_q;
  logic             half_end;
  logic             load_now;
  logic             shift_now;
  logic             last_bit;

  assign half_end  = (div_cnt == DIV_W'(SCK_HALF - 1));
  assign last_bit  = (bit_cnt == 3'd7);
  assign load_now  = (state == S_REQ) && i_spi_ack;
  // Falling SCK edge that moves on to the next bit.
  assign shift_now = (state == S_SHIFT) && half_end && o_sck && !last_bit;

  // Pop and done are the same pulse.
  assign o_pop      = done_q;
  assign o_spi_done = done_q;
  assign o_idle     = (state == S_IDLE) && !i_entry_valid;

  always_ff @(posedge clk) begin
    if (load_now) begin
      shreg <= i_entry.payload;
    end else if (shift_now) begin
      shreg <= {shreg[6:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state     <= S_IDLE;
      o_spi_req <= 1'b0;
      done_q    <= 1'b0;
      o_sck     <= 1'b0;
      o_cs      <= 1'b1;
      o_rs_dc   <= 1'b0;
      o_data    <= 1'b0;
      div_cnt   <= '0;
      bit_cnt   <= '0;
    end else begin
      done_q <= 1'b0;
      case (state)
        S_IDLE: begin
          // The head still shows the popped entry during the done cycle.
          if (i_entry_valid && !done_q) begin
            o_spi_req <= 1'b1;
            state     <= S_REQ;
          end
        end
        S_REQ: begin
          if (i_spi_ack) begin
            o_cs    <= 1'b0;
            o_rs_dc <= !i_entry.cmd;
            o_data  <= i_entry.payload[7];
            div_cnt <= '0;
            bit_cnt <= '0;
            state   <= S_SHIFT;
          end
        end
        S_SHIFT: begin
          if (half_end) begin
            div_cnt <= '0;
            if (!o_sck) begin
              o_sck <= 1'b1;
            end else begin
              o_sck <= 1'b0;
              if (last_bit) begin
                state <= S_FINISH;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
                o_data  <= shreg[6];
              end
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        S_FINISH: begin
          // Release the pins and hand the bus back.
          o_spi_req <= 1'b0;
          o_cs      <= 1'b1;
          done_q    <= 1'b1;
          state     <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: source/spi_lcd_ctrl.sv
`timescale 1ns/1ps

module spi_lcd_ctrl #(
  parameter int FIFO_DEPTH = 8,
  parameter int SCK_HALF   = 2
) (
  input  logic        clk,
  input  logic        i_rst_n,
  input  logic        i_bus_req,
  input  logic        i_bus_write,
  input  logic [31:0] i_bus_addr,
  input  logic [31:0] i_bus_data,
  output logic        o_bus_ack,
  output logic [31:0] o_bus_data,
  input  logic        i_spi_ack,
  output logic        o_spi_req,
  output logic        o_spi_done,
  output logic        o_sck,
  output logic        o_cs,
  output logic        o_rs_dc,
  output logic        o_data
);

  logic                    push_valid;
  spi_lcd_pkg::lcd_entry_t push_entry;
  logic                    credit_return;
  spi_lcd_pkg::lcd_entry_t head;
  logic                    not_empty;
  logic                    pop;
  logic                    idle;

  lcd_bus_regs #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_regs (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_bus_req      (i_bus_req),
    .i_bus_write    (i_bus_write),
    .i_bus_addr     (i_bus_addr),
    .i_bus_data     (i_bus_data),
    .i_credit_return(credit_return),
    .i_idle         (idle),
    .o_bus_ack      (o_bus_ack),
    .o_bus_data     (o_bus_data),
    .o_push_valid   (push_valid),
    .o_push_entry   (push_entry)
  );

  entry_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_push_valid   (push_valid),
    .i_push_entry   (push_entry),
    .i_pop          (pop),
    .o_head         (head),
    .o_not_empty    (not_empty),
    .o_credit_return(credit_return)
  );

  spi_byte_shifter #(
    .SCK_HALF(SCK_HALF)
  ) u_shifter (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_entry      (head),
    .i_entry_valid(not_empty),
    .i_spi_ack    (i_spi_ack),
    .o_pop        (pop),
    .o_spi_req    (o_spi_req),
    .o_spi_done   (o_spi_done),
    .o_sck        (o_sck),
    .o_cs         (o_cs),
    .o_rs_dc      (o_rs_dc),
    .o_data       (o_data),
    .o_idle       (idle)
  );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk
);

  // Free-running clock, starts low.
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk = ~clk;
    end
  end

endmodule

// File: test/spi_lcd_ctrl_tb.sv
`timescale 1ns/1ps

module spi_lcd_ctrl_tb;

  localparam int FIFO_DEPTH = 8;
  localparam int SCK_HALF   = 2;
  localparam int STREAM_LEN = 200;
  localparam int NUM_BYTES  = STREAM_LEN + 8 + 11;
  localparam int LIMIT      = NUM_BYTES * (16 * SCK_HALF + 12) + 4000;

  logic        clk;
  logic        i_rst_n;
  logic        i_bus_req;
  logic        i_bus_write;
  logic [31:0] i_bus_addr;
  logic [31:0] i_bus_data;
  logic        o_bus_ack;
  logic [31:0] o_bus_data;
  logic        i_spi_ack = 1'b0;
  logic        o_spi_req;
  logic        o_spi_done;
  logic        o_sck;
  logic        o_cs;
  logic        o_rs_dc;
  logic        o_data;

  integer                  seed;
  string                   test_name = "reset";
  logic                    arb_hold;
  int                      arb_delay [NUM_BYTES];
  int                      arb_wait;
  int                      grant_idx;
  spi_lcd_pkg::lcd_entry_t ref_q [$];
  spi_lcd_pkg::lcd_entry_t exp_entry;
  spi_lcd_pkg::lcd_entry_t rx_entry;
  logic                    byte_wr;
  int                      model_credits = FIFO_DEPTH;
  int                      accepted_cnt = 0;
  int                      done_cnt = 0;
  int                      rx_cnt = 0;
  int                      rx_bits;
  logic [7:0]              rx_shift;
  logic                    byte_ready;
  logic                    ack_seen;
  logic                    prev_sck;
  logic                    prev_cs;
  logic                    prev_req;
  logic                    prev_done;
  logic [31:0]             rd;
  int                      gap;
  logic [13:0]             idx;

  tb_clock_gen #(.PERIOD_NS(8.0)) u_clk (.clk(clk));

  spi_lcd_ctrl #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .SCK_HALF  (SCK_HALF)
  ) uut (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_bus_req  (i_bus_req),
    .i_bus_write(i_bus_write),
    .i_bus_addr (i_bus_addr),
    .i_bus_data (i_bus_data),
    .o_bus_ack  (o_bus_ack),
    .o_bus_data (o_bus_data),
    .i_spi_ack  (i_spi_ack),
    .o_spi_req  (o_spi_req),
    .o_spi_done (o_spi_done),
    .o_sck      (o_sck),
    .o_cs       (o_cs),
    .o_rs_dc    (o_rs_dc),
    .o_data     (o_data)
  );

  task automatic report_violation(input string what);
    $display("Protocol problem in %s: %s", test_name, what);
    $display("Test failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_entry(input string name, input spi_lcd_pkg::lcd_entry_t exp,
                             input spi_lcd_pkg::lcd_entry_t act);
    if (act !== exp) begin
      $display("** Error %s: expected cmd=%0b data=%02h, actual cmd=%0b data=%02h",
               name, exp.cmd, exp.payload, act.cmd, act.payload);
      $display("Test failed");
      $fatal(1, "run stopped at the first error");
    end
  endtask

  task automatic check_status(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s: expected %08h, actual %08h", name, exp, act);
      $display("Test failed");
      $fatal(1, "run stopped at the first error");
    end
  endtask

  function automatic logic [31:0] make_status(input logic idle, input logic ovf,
                                              input int credits);
    logic [31:0] w;
    w = '0;
    w[spi_lcd_pkg::STAT_IDLE_BIT] = idle;
    w[spi_lcd_pkg::STAT_OVF_BIT]  = ovf;
    w[spi_lcd_pkg::STAT_CREDIT_LSB +: 8] = 8'(credits);
    return w;
  endfunction

  // One bus access; ack is due exactly one cycle after the request.
  task automatic bus_cycle(input logic wr, input logic [13:0] word, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    @(posedge clk);
    i_bus_req   <= 1'b1;
    i_bus_write <= wr;
    i_bus_addr  <= {16'd0, word, 2'b00};
    i_bus_data  <= wdata;
    @(posedge clk);
    i_bus_req <= 1'b0;
    @(posedge clk);
    if (o_bus_ack !== 1'b1) begin
      report_violation("bus ack did not come one cycle after the request");
    end
    rdata = o_bus_data;
  endtask

  task automatic write_reg(input logic [13:0] word, input logic [31:0] wdata);
    logic [31:0] rdata;
    bus_cycle(1'b1, word, wdata, rdata);
    check_status({test_name, " write data"}, 32'd0, rdata);
  endtask

  task automatic read_status(output logic [31:0] rdata);
    bus_cycle(1'b0, spi_lcd_pkg::REG_STATUS, 32'd0, rdata);
  endtask

  task automatic wait_drain(input int expect_rx);
    @(negedge clk);
    while (done_cnt != accepted_cnt) begin
      @(negedge clk);
    end
    if (rx_cnt != expect_rx || done_cnt != rx_cnt) begin
      report_violation($sformatf("expected %0d bytes on SPI, saw %0d with %0d done pulses",
                                 expect_rx, rx_cnt, done_cnt));
    end
  endtask

  // A byte write is queued only while a credit is left.
  always @(posedge clk) begin
    if (!i_rst_n) begin
      model_credits = FIFO_DEPTH;
      accepted_cnt  = 0;
      done_cnt      = 0;
    end else begin
      byte_wr = i_bus_req && i_bus_write &&
                (i_bus_addr[15:2] == spi_lcd_pkg::REG_CMD ||
                 i_bus_addr[15:2] == spi_lcd_pkg::REG_DATA);
      if (byte_wr && model_credits > 0) begin
        exp_entry.cmd     = (i_bus_addr[15:2] == spi_lcd_pkg::REG_CMD);
        exp_entry.payload = i_bus_data[7:0];
        ref_q.push_back(exp_entry);
        model_credits = model_credits - 1;
        accepted_cnt  = accepted_cnt + 1;
      end
      if (o_spi_done) begin
        model_credits = model_credits + 1;
        done_cnt      = done_cnt + 1;
      end
    end
  end

  // Arbiter with a random grant delay, or no grant while held.
  always @(posedge clk) begin
    if (!i_rst_n) begin
      i_spi_ack <= 1'b0;
      grant_idx = 0;
      arb_wait  = arb_delay[0];
    end else if (!o_spi_req) begin
      i_spi_ack <= 1'b0;
    end else if (!arb_hold && !i_spi_ack) begin
      if (arb_wait == 0) begin
        i_spi_ack <= 1'b1;
        grant_idx = grant_idx + 1;
        arb_wait  = arb_delay[grant_idx % NUM_BYTES];
      end else begin
        arb_wait = arb_wait - 1;
      end
    end
  end

  // SPI receiver and handshake monitor.
  always @(posedge clk) begin
    if (!i_rst_n) begin
      rx_bits    = 0;
      rx_cnt     = 0;
      byte_ready = 1'b0;
      ack_seen   = 1'b0;
      prev_sck   = 1'b0;
      prev_cs    = 1'b1;
      prev_req   = 1'b0;
      prev_done  = 1'b0;
    end else begin
      if (prev_cs && !o_cs && !ack_seen) begin
        report_violation("chip select fell before the bus was granted");
      end
      if (o_spi_req && i_spi_ack) begin
        ack_seen = 1'b1;
      end
      // Mode 0 samples on the rising SCK edge.
      if (o_sck && !prev_sck && !o_cs) begin
        rx_shift = {rx_shift[6:0], o_data};
        rx_bits  = rx_bits + 1;
        if (rx_bits == 8) begin
          if (byte_ready) begin
            report_violation("a second byte arrived before done");
          end
          if (ref_q.size() == 0) begin
            report_violation("a byte arrived on SPI that was never accepted");
          end
          rx_entry.cmd     = !o_rs_dc;
          rx_entry.payload = rx_shift;
          check_entry({test_name, " spi byte"}, ref_q.pop_front(), rx_entry);
          rx_bits    = 0;
          rx_cnt     = rx_cnt + 1;
          byte_ready = 1'b1;
        end
      end
      if ((prev_req && !o_spi_req) != o_spi_done) begin
        report_violation("request and done did not drop and pulse in the same cycle");
      end
      if (o_spi_done) begin
        if (prev_done) begin
          report_violation("done stayed high for more than one cycle");
        end
        if (!byte_ready) begin
          report_violation("done pulsed without a full byte on SPI");
        end
        byte_ready = 1'b0;
        ack_seen   = 1'b0;
      end
      prev_sck  = o_sck;
      prev_cs   = o_cs;
      prev_req  = o_spi_req;
      prev_done = o_spi_done;
    end
  end

  initial begin
    seed        = 32'h561d;
    i_rst_n     = 1'b0;
    i_bus_req   = 1'b0;
    i_bus_write = 1'b0;
    i_bus_addr  = '0;
    i_bus_data  = '0;
    arb_hold    = 1'b0;
    for (int i = 0; i < NUM_BYTES; i++) begin
      arb_delay[i] = $random(seed) & 7;
    end
    repeat (8) @(posedge clk);
    i_rst_n <= 1'b1;

    @(negedge clk);
    if (o_cs !== 1'b1 || o_sck !== 1'b0 || o_spi_req !== 1'b0 ||
        o_spi_done !== 1'b0 || o_bus_ack !== 1'b0) begin
      report_violation("outputs were not in their reset state");
    end
    read_status(rd);
    check_status("reset status", make_status(1'b1, 1'b0, FIFO_DEPTH), rd);

    test_name = "stream";
    for (int n = 0; n < STREAM_LEN; n++) begin
      gap = $random(seed) & 7;
      repeat (gap) @(posedge clk);
      @(negedge clk);
      while (model_credits == 0) begin
        @(negedge clk);
      end
      idx = (($random(seed) & 1) != 0) ? spi_lcd_pkg::REG_CMD : spi_lcd_pkg::REG_DATA;
      write_reg(idx, 32'($random(seed)));
    end
    wait_drain(STREAM_LEN);
    test_name = "drain";
    read_status(rd);
    check_status("drain status", make_status(1'b1, 1'b0, FIFO_DEPTH), rd);

    // Back-pressure fills every slot.
    test_name = "backpressure";
    arb_hold <= 1'b1;
    for (int n = 0; n < 8; n++) begin
      write_reg(spi_lcd_pkg::REG_DATA, 32'($random(seed)));
    end
    read_status(rd);
    check_status("full status", make_status(1'b0, 1'b0, 0), rd);
    arb_hold <= 1'b0;
    wait_drain(STREAM_LEN + 8);

    test_name = "overflow";
    arb_hold <= 1'b1;
    for (int n = 0; n < 11; n++) begin
      idx = (n % 3 == 0) ? spi_lcd_pkg::REG_CMD : spi_lcd_pkg::REG_DATA;
      write_reg(idx, 32'($random(seed)));
    end
    read_status(rd);
    check_status("overflow status", make_status(1'b0, 1'b1, 0), rd);
    arb_hold <= 1'b0;
    wait_drain(STREAM_LEN + 16);
    read_status(rd);
    check_status("sticky overflow", make_status(1'b1, 1'b1, FIFO_DEPTH), rd);
    write_reg(spi_lcd_pkg::REG_STATUS, 32'h2);
    read_status(rd);
    check_status("overflow cleared", make_status(1'b1, 1'b0, FIFO_DEPTH), rd);

    $display("Test passed");
    $finish;
  end

  // Budget scales with the number of bytes sent.
  initial begin
    repeat (LIMIT) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the controller appears to hang", LIMIT);
    $display("Test failed");
    $fatal(1, "run stopped by the watchdog");
  end

endmodule

// File: project.f
source/spi_lcd_pkg.sv
source/lcd_bus_regs.sv
source/entry_fifo.sv
source/spi_byte_shifter.sv
source/spi_lcd_ctrl.sv
test/tb_clock_gen.sv
test/spi_lcd_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; the exit status gives the result.
cd "$(dirname "$0")" &&
  verilator --binary --timing -j 0 --top-module spi_lcd_ctrl_tb -f project.f \
    -o sim_spi_lcd_ctrl &&
  ./obj_dir/sim_spi_lcd_ctrl ||
  { echo "simulation build or run did not succeed"; exit 1; }
